/* hw/mem_wb_pkg.sv */
// memory/writeback back end shared definitions
// pipeline packets, ALU result union, memory and register file sizes

`default_nettype none

package mem_wb_pkg;

        localparam int DATA_W    = 32;
        localparam int REG_AW    = 5;
        localparam int IMM_W     = 16;
        localparam int RAM_WORDS = 256;
        localparam int RAM_AW    = $clog2(RAM_WORDS);

        // data RAM wait states per access
        localparam int DMEM_WAIT = 2;
        localparam int WAIT_CW   = $clog2(DMEM_WAIT + 1);

        typedef logic [WAIT_CW-1:0] wait_cnt_t;
        localparam wait_cnt_t WAIT_LOAD = wait_cnt_t'(DMEM_WAIT);

        // jal link register
        localparam logic [REG_AW-1:0] RA_REG = 5'd31;

        // ALU result seen as a data memory address
        typedef struct packed {
                logic [DATA_W-RAM_AW-3:0] upper;
                logic [RAM_AW-1:0]        word;
                logic [1:0]               offset;
        } dmem_addr_t;

        typedef union packed {
                logic [DATA_W-1:0] raw;
                dmem_addr_t        addr;
        } alu_word_u;

        // packet handed over by execute
        typedef struct packed {
                logic              RegWr;
                logic              MemtoReg;
                logic              MemRead;
                logic              MemWrite;
                logic              jal;
                logic              RegDst;
                logic              LUI;
                logic              halt;
                logic [DATA_W-1:0] NPC;
                logic [REG_AW-1:0] Rd;
                logic [REG_AW-1:0] Rt;
                alu_word_u         port_o;
                logic [DATA_W-1:0] store_data;
                logic [IMM_W-1:0]  imm;
        } ex_mem_t;

        // registered writeback packet
        typedef struct packed {
                logic              RegWr;
                logic              MemtoReg;
                logic              jal;
                logic              RegDst;
                logic              LUI;
                logic              halt;
                logic [DATA_W-1:0] NPC;
                logic [REG_AW-1:0] Rd;
                logic [REG_AW-1:0] Rt;
                alu_word_u         port_o;
                logic [DATA_W-1:0] dmemload;
                logic [IMM_W-1:0]  imm;
        } mem_wb_t;

        typedef struct packed {
                logic              en;
                logic [REG_AW-1:0] addr;
                logic [DATA_W-1:0] data;
        } reg_write_t;

        typedef enum logic [1:0] {
                IDLE,
                ACCESS,
                DONE
        } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/wait_timer.sv */
// data RAM wait state timer
// loads the wait count on start and pulses expired on the last cycle

`default_nettype none

module wait_timer (
        input  logic CLK,
        input  logic nRST,
        input  logic start,
        output logic expired
);

        mem_wb_pkg::wait_cnt_t count;

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        count <= '0;
                end else if (start) begin
                        count <= mem_wb_pkg::WAIT_LOAD;
                end else if (count != '0) begin
                        count <= count - 1'b1;
                end
        end

        // high in the last wait cycle before the count reaches zero
        assign expired = (count == mem_wb_pkg::wait_cnt_t'(1));

endmodule

`default_nettype wire

/* hw/dmem_ctrl.sv */
// data memory controller
// sequences one word load or store and generates advance, dhit and stall

`default_nettype none

module dmem_ctrl (
        input  logic                                CLK,
        input  logic                                nRST,
        input  logic                                ihit,
        input  mem_wb_pkg::ex_mem_t                 ex_pkt,
        input  logic                                expired,
        output logic                                start,
        output logic                                ram_en,
        output logic                                ram_we,
        output logic [mem_wb_pkg::RAM_AW-1:0]       ram_addr,
        output logic [mem_wb_pkg::DATA_W-1:0]       ram_wdata,
        output mem_wb_pkg::ex_mem_t                 held_pkt,
        output logic                                advance,
        output logic                                dhit,
        output logic                                stall
);

        mem_wb_pkg::ctrl_state_e state;
        mem_wb_pkg::ctrl_state_e next_state;
        mem_wb_pkg::ex_mem_t     pend_pkt;
        logic                    mem_op;
        logic                    accept;
        logic                    accept_mem;

        assign mem_op     = ex_pkt.MemRead | ex_pkt.MemWrite;
        assign accept     = ihit & (state == mem_wb_pkg::IDLE);
        assign accept_mem = accept & mem_op;

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        state <= mem_wb_pkg::IDLE;
                        start <= 1'b0;
                end else begin
                        state <= next_state;
                        // timer starts one cycle after acceptance
                        start <= accept_mem;
                end
        end

        // pending load/store packet
        always_ff @(posedge CLK) begin
                if (accept_mem) begin
                        pend_pkt <= ex_pkt;
                end
        end

        always_comb begin
                next_state = state;
                case (state)
                        mem_wb_pkg::IDLE: begin
                                if (accept_mem) begin
                                        next_state = mem_wb_pkg::ACCESS;
                                end
                        end
                        mem_wb_pkg::ACCESS: begin
                                if (expired) begin
                                        next_state = mem_wb_pkg::DONE;
                                end
                        end
                        mem_wb_pkg::DONE: next_state = mem_wb_pkg::IDLE;
                        default:          next_state = mem_wb_pkg::IDLE;
                endcase
        end

        // RAM access on the edge that leaves ACCESS
        assign ram_en    = (state == mem_wb_pkg::ACCESS) & expired;
        assign ram_we    = ram_en & pend_pkt.MemWrite;
        assign ram_addr  = pend_pkt.port_o.addr.word;
        assign ram_wdata = pend_pkt.store_data;

        assign stall    = (state != mem_wb_pkg::IDLE);
        assign dhit     = (state == mem_wb_pkg::DONE);
        // non-memory packets advance straight from ihit
        assign advance  = (accept & ~mem_op) | dhit;
        assign held_pkt = (state == mem_wb_pkg::IDLE) ? ex_pkt : pend_pkt;

endmodule

`default_nettype wire

/* hw/data_ram.sv */
// data RAM
// single port, word addressed, registered read data

`default_nettype none

module data_ram (
        input  logic                          CLK,
        input  logic                          en,
        input  logic                          we,
        input  logic [mem_wb_pkg::RAM_AW-1:0] addr,
        input  logic [mem_wb_pkg::DATA_W-1:0] wdata,
        output logic [mem_wb_pkg::DATA_W-1:0] rdata
);

        logic [mem_wb_pkg::DATA_W-1:0] mem [mem_wb_pkg::RAM_WORDS];

        // start from a cleared memory
        initial begin
                for (int i = 0; i < mem_wb_pkg::RAM_WORDS; i++) begin
                        mem[i] = '0;
                end
        end

        always_ff @(posedge CLK) begin
                if (en) begin
                        if (we) begin
                                mem[addr] <= wdata;
                        end else begin
                                rdata <= mem[addr];
                        end
                end
        end

endmodule

`default_nettype wire

/* hw/memwb.sv */
// MEM/WB pipeline register
// loads the writeback fields and loaded word when the memory stage advances

`default_nettype none

module memwb (
        input  logic                          CLK,
        input  logic                          nRST,
        input  logic                          advance,
        input  mem_wb_pkg::ex_mem_t           ex_pkt,
        input  logic [mem_wb_pkg::DATA_W-1:0] dmemload,
        output mem_wb_pkg::mem_wb_t           mwb
);

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        // all-zero no-op
                        mwb <= '0;
                end else if (advance) begin
                        mwb.RegWr    <= ex_pkt.RegWr;
                        mwb.MemtoReg <= ex_pkt.MemtoReg;
                        mwb.jal      <= ex_pkt.jal;
                        mwb.RegDst   <= ex_pkt.RegDst;
                        mwb.LUI      <= ex_pkt.LUI;
                        mwb.halt     <= ex_pkt.halt;

                        mwb.NPC      <= ex_pkt.NPC;
                        mwb.Rd       <= ex_pkt.Rd;
                        mwb.Rt       <= ex_pkt.Rt;
                        mwb.port_o   <= ex_pkt.port_o;
                        mwb.imm      <= ex_pkt.imm;
                        mwb.dmemload <= dmemload;
                end else begin
                        // held instruction writes the register file only once
                        mwb.RegWr <= 1'b0;
                end
        end

endmodule

`default_nettype wire

/* hw/regfile_wb.sv */
// writeback select and register file
// picks value and destination, writes 32 registers, one async read port

`default_nettype none

module regfile_wb (
        input  logic                          CLK,
        input  logic                          nRST,
        input  mem_wb_pkg::mem_wb_t           mwb,
        input  logic [mem_wb_pkg::REG_AW-1:0] rd_sel,
        output mem_wb_pkg::reg_write_t        rf_wr,
        output logic [mem_wb_pkg::DATA_W-1:0] rd_data
);

        logic [mem_wb_pkg::DATA_W-1:0] regs [2**mem_wb_pkg::REG_AW];
        logic [mem_wb_pkg::DATA_W-1:0] wr_value;
        logic [mem_wb_pkg::REG_AW-1:0] wr_dest;

        // jal over load over lui over alu
        always_comb begin
                if (mwb.jal) begin
                        wr_value = mwb.NPC;
                end else if (mwb.MemtoReg) begin
                        wr_value = mwb.dmemload;
                end else if (mwb.LUI) begin
                        wr_value = {mwb.imm, {(mem_wb_pkg::DATA_W - mem_wb_pkg::IMM_W){1'b0}}};
                end else begin
                        wr_value = mwb.port_o.raw;
                end
        end

        always_comb begin
                if (mwb.jal) begin
                        wr_dest = mem_wb_pkg::RA_REG;
                end else if (mwb.RegDst) begin
                        wr_dest = mwb.Rd;
                end else begin
                        wr_dest = mwb.Rt;
                end
        end

        // $zero stays zero
        assign rf_wr.en   = mwb.RegWr & (wr_dest != '0);
        assign rf_wr.addr = wr_dest;
        assign rf_wr.data = wr_value;

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        for (int i = 0; i < 2**mem_wb_pkg::REG_AW; i++) begin
                                regs[i] <= '0;
                        end
                end else if (rf_wr.en) begin
                        regs[rf_wr.addr] <= rf_wr.data;
                end
        end

        assign rd_data = regs[rd_sel];

endmodule

`default_nettype wire

/* hw/mem_wb_top.sv */
// memory stage and writeback back end
// controller, wait timer, data RAM, MEM/WB register and register file

`default_nettype none

module mem_wb_top (
        input  logic                          CLK,
        input  logic                          nRST,
        input  mem_wb_pkg::ex_mem_t           ex_pkt,
        input  logic                          ihit,
        input  logic [mem_wb_pkg::REG_AW-1:0] rd_sel,
        output logic                          stall,
        output mem_wb_pkg::reg_write_t        rf_wr,
        output logic [mem_wb_pkg::DATA_W-1:0] rd_data,
        output logic                          halt
);

        logic                          start;
        logic                          expired;
        logic                          ram_en;
        logic                          ram_we;
        logic [mem_wb_pkg::RAM_AW-1:0] ram_addr;
        logic [mem_wb_pkg::DATA_W-1:0] ram_wdata;
        logic [mem_wb_pkg::DATA_W-1:0] ram_rdata;
        logic                          advance;
        mem_wb_pkg::ex_mem_t           held_pkt;
        mem_wb_pkg::mem_wb_t           mwb;

        // dhit is already folded into advance
        dmem_ctrl u_ctrl (
                .CLK       (CLK),
                .nRST      (nRST),
                .ihit      (ihit),
                .ex_pkt    (ex_pkt),
                .expired   (expired),
                .start     (start),
                .ram_en    (ram_en),
                .ram_we    (ram_we),
                .ram_addr  (ram_addr),
                .ram_wdata (ram_wdata),
                .held_pkt  (held_pkt),
                .advance   (advance),
                .dhit      (),
                .stall     (stall)
        );

        wait_timer u_timer (
                .CLK     (CLK),
                .nRST    (nRST),
                .start   (start),
                .expired (expired)
        );

        data_ram u_ram (
                .CLK   (CLK),
                .en    (ram_en),
                .we    (ram_we),
                .addr  (ram_addr),
                .wdata (ram_wdata),
                .rdata (ram_rdata)
        );

        memwb u_memwb (
                .CLK      (CLK),
                .nRST     (nRST),
                .advance  (advance),
                .ex_pkt   (held_pkt),
                .dmemload (ram_rdata),
                .mwb      (mwb)
        );

        regfile_wb u_rf (
                .CLK     (CLK),
                .nRST    (nRST),
                .mwb     (mwb),
                .rd_sel  (rd_sel),
                .rf_wr   (rf_wr),
                .rd_data (rd_data)
        );

        assign halt = mwb.halt;

endmodule

`default_nettype wire

/* bench/mem_wb_tb.sv */
// testbench for the memory stage and writeback back end
// directed and random packets checked write by write against a reference model

`default_nettype none

module mem_wb_tb;

        timeunit 1ns;
        timeprecision 100ps;

        localparam int N_RANDOM = 200;
        // random mix plus the directed packets
        localparam int N_PKTS   = N_RANDOM + 10;
        localparam int MEM_LAT  = mem_wb_pkg::DMEM_WAIT + 2;
        localparam int N_REGS   = 2**mem_wb_pkg::REG_AW;
        localparam int WD_LIMIT = N_PKTS * 8 + 100;

        logic                          CLK;
        logic                          nRST;
        mem_wb_pkg::ex_mem_t           ex_pkt;
        logic                          ihit;
        logic [mem_wb_pkg::REG_AW-1:0] rd_sel;
        logic                          stall;
        mem_wb_pkg::reg_write_t        rf_wr;
        logic [mem_wb_pkg::DATA_W-1:0] rd_data;
        logic                          halt;

        // reference state
        logic [mem_wb_pkg::DATA_W-1:0] model_regs [N_REGS];
        logic [mem_wb_pkg::DATA_W-1:0] model_ram [mem_wb_pkg::RAM_WORDS];
        logic [31:0]                   rng_state = 32'h494c_526d;

        mem_wb_pkg::reg_write_t exp_q [$];
        int                     due_q [$];
        int                     cyc = 0;
        int                     err_count = 0;
        int                     test_num = 0;
        int                     test_fails = 0;
        int                     test_err_base = 0;

        mem_wb_top dut (
                .CLK     (CLK),
                .nRST    (nRST),
                .ex_pkt  (ex_pkt),
                .ihit    (ihit),
                .rd_sel  (rd_sel),
                .stall   (stall),
                .rf_wr   (rf_wr),
                .rd_data (rd_data),
                .halt    (halt)
        );

        always begin
                #5 CLK = ~CLK;
        end

        always @(posedge CLK) begin
                cyc <= cyc + 1;
        end

        function automatic logic [31:0] next_rand();
                rng_state = rng_state * 32'd1664525 + 32'd1013904223;
                return rng_state;
        endfunction

        function automatic logic [31:0] word_addr(input int word, input logic [1:0] offset);
                return (32'(word) << 2) | 32'(offset);
        endfunction

        // expected write of one packet and the matching model RAM and register update
        function automatic mem_wb_pkg::reg_write_t model_step(input mem_wb_pkg::ex_mem_t p);
                mem_wb_pkg::reg_write_t        w;
                logic [mem_wb_pkg::DATA_W-1:0] loaded;
                int                            idx;
                idx = int'((p.port_o.raw >> 2) % mem_wb_pkg::RAM_WORDS);
                loaded = '0;
                if (p.MemWrite) begin
                        model_ram[idx] = p.store_data;
                end
                if (p.MemRead) begin
                        loaded = model_ram[idx];
                end
                if (p.jal) begin
                        w.data = p.NPC;
                end else if (p.MemtoReg) begin
                        w.data = loaded;
                end else if (p.LUI) begin
                        w.data = {p.imm, 16'h0000};
                end else begin
                        w.data = p.port_o.raw;
                end
                if (p.jal) begin
                        w.addr = mem_wb_pkg::RA_REG;
                end else if (p.RegDst) begin
                        w.addr = p.Rd;
                end else begin
                        w.addr = p.Rt;
                end
                w.en = p.RegWr && (w.addr != '0);
                if (w.en) begin
                        model_regs[w.addr] = w.data;
                end
                return w;
        endfunction

        // plain ALU packet with random fields
        function automatic mem_wb_pkg::ex_mem_t base_pkt();
                mem_wb_pkg::ex_mem_t p;
                logic [31:0]         r;
                p = '0;
                p.RegWr = 1'b1;
                p.NPC = next_rand();
                p.port_o.raw = next_rand();
                p.store_data = next_rand();
                r = next_rand();
                p.Rd = r[31:27];
                p.Rt = r[26:22];
                p.imm = r[21:6];
                return p;
        endfunction

        function automatic mem_wb_pkg::ex_mem_t random_pkt();
                mem_wb_pkg::ex_mem_t p;
                logic [31:0]         r;
                p = base_pkt();
                r = next_rand();
                p.RegDst = r[17];
                if (r[20:18] == 3'd0) begin
                        p.RegWr = 1'b0;
                end
                case (r[31:29])
                        3'd0, 3'd1: begin
                                p.MemRead = 1'b1;
                                p.MemtoReg = 1'b1;
                                p.RegWr = 1'b1;
                                p.RegDst = 1'b0;
                                p.port_o.raw = word_addr(r[27:23], r[22:21]);
                        end
                        3'd2, 3'd3: begin
                                p.MemWrite = 1'b1;
                                p.RegWr = 1'b0;
                                p.port_o.raw = word_addr(r[27:23], r[22:21]);
                        end
                        3'd4: p.LUI = 1'b1;
                        3'd5: p.jal = 1'b1;
                        default: ;
                endcase
                return p;
        endfunction

        task automatic check_write(input mem_wb_pkg::reg_write_t got,
                                   input mem_wb_pkg::reg_write_t exp);
                if (got.en !== exp.en) begin
                        $display("MISMATCH rf_wr.en got %h expected %h", got.en, exp.en);
                        err_count++;
                end else if (exp.en) begin
                        if (got.addr !== exp.addr) begin
                                $display("MISMATCH rf_wr.addr got %h expected %h",
                                         got.addr, exp.addr);
                                err_count++;
                        end
                        if (got.data !== exp.data) begin
                                $display("MISMATCH rf_wr.data got %h expected %h",
                                         got.data, exp.data);
                                err_count++;
                        end
                end
        endtask

        task automatic check_word(input string name, input logic [mem_wb_pkg::DATA_W-1:0] got,
                                  input logic [mem_wb_pkg::DATA_W-1:0] exp);
                if (got !== exp) begin
                        $display("MISMATCH %s got %h expected %h", name, got, exp);
                        err_count++;
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("MISMATCH %s got %h expected %h", name, got, exp);
                        err_count++;
                end
        endtask

        task automatic check_count(input string name, input int got, input int exp);
                if (got != exp) begin
                        $display("MISMATCH %s got %0h expected %0h", name, got, exp);
                        err_count++;
                end
        endtask

        // offers one packet once stall is low and logs its expected write
        task automatic send_pkt(input mem_wb_pkg::ex_mem_t p);
                mem_wb_pkg::reg_write_t w;
                logic                   mem_op;
                int                     stall_cycles;
                mem_op = p.MemRead | p.MemWrite;
                @(negedge CLK);
                while (stall) begin
                        @(negedge CLK);
                end
                @(posedge CLK);
                ex_pkt <= p;
                ihit <= 1'b1;
                @(posedge CLK);
                ihit <= 1'b0;
                w = model_step(p);
                if (w.en) begin
                        exp_q.push_back(w);
                        due_q.push_back(cyc + 1 + (mem_op ? MEM_LAT : 0));
                end
                if (mem_op) begin
                        stall_cycles = 0;
                        @(negedge CLK);
                        while (stall) begin
                                stall_cycles++;
                                @(negedge CLK);
                        end
                        check_count("stall cycles", stall_cycles, MEM_LAT);
                end
        endtask

        task automatic read_reg(input int idx, output logic [mem_wb_pkg::DATA_W-1:0] val);
                @(posedge CLK);
                rd_sel <= idx[mem_wb_pkg::REG_AW-1:0];
                @(negedge CLK);
                val = rd_data;
        endtask

        task automatic check_all_regs();
                logic [mem_wb_pkg::DATA_W-1:0] val;
                for (int i = 0; i < N_REGS; i++) begin
                        read_reg(i, val);
                        check_word($sformatf("rd_data r%0d", i), val, model_regs[i]);
                end
        endtask

        task automatic wait_writes();
                while (exp_q.size() != 0) begin
                        @(negedge CLK);
                end
                // last write commits on the next edge
                @(posedge CLK);
                @(negedge CLK);
        endtask

        task automatic end_test(input string name);
                int errs;
                wait_writes();
                errs = err_count - test_err_base;
                test_num++;
                if (errs == 0) begin
                        $display("test %0d %s: ok", test_num, name);
                end else begin
                        $display("test %0d %s: %0d errors", test_num, name, errs);
                        test_fails++;
                end
                test_err_base = err_count;
        endtask

        // rf_wr against the write that is due in this cycle
        always @(negedge CLK) begin
                if (nRST) begin
                        if (due_q.size() != 0 && due_q[0] == cyc) begin
                                due_q.delete(0);
                                check_write(rf_wr, exp_q.pop_front());
                        end else if (rf_wr.en) begin
                                $display("unexpected register write to r%0d at cycle %0d",
                                         rf_wr.addr, cyc);
                                err_count++;
                        end
                end
        end

        initial begin
                repeat (WD_LIMIT) @(posedge CLK);
                $display("watchdog: run did not complete within %0d cycles", WD_LIMIT);
                $display(">>> FAIL");
                $finish;
        end

        initial begin
                mem_wb_pkg::ex_mem_t           p;
                logic [mem_wb_pkg::DATA_W-1:0] val;
                CLK = 1'b0;
                nRST = 1'b0;
                ihit = 1'b0;
                ex_pkt = '0;
                rd_sel = '0;
                for (int i = 0; i < N_REGS; i++) begin
                        model_regs[i] = '0;
                end
                for (int i = 0; i < mem_wb_pkg::RAM_WORDS; i++) begin
                        model_ram[i] = '0;
                end
                repeat (8) @(posedge CLK);
                nRST <= 1'b1;

                @(negedge CLK);
                check_flag("stall", stall, 1'b0);
                check_flag("halt", halt, 1'b0);
                check_flag("rf_wr.en", rf_wr.en, 1'b0);
                check_all_regs();
                end_test("reset state");

                p = base_pkt();
                p.Rt = 5'd3;
                send_pkt(p);
                p = base_pkt();
                p.RegDst = 1'b1;
                p.Rd = 5'd4;
                send_pkt(p);
                p = base_pkt();
                p.LUI = 1'b1;
                p.Rt = 5'd5;
                p.imm = 16'h1234;
                send_pkt(p);
                // jal wins over lui and RegDst
                p = base_pkt();
                p.jal = 1'b1;
                p.LUI = 1'b1;
                p.RegDst = 1'b1;
                send_pkt(p);
                p = base_pkt();
                p.Rt = 5'd0;
                send_pkt(p);
                p = base_pkt();
                p.RegWr = 1'b0;
                p.Rt = 5'd7;
                send_pkt(p);
                end_test("alu lui jal writeback");

                p = base_pkt();
                p.MemWrite = 1'b1;
                p.RegWr = 1'b0;
                p.port_o.raw = word_addr(5, 2'd0);
                p.store_data = 32'hcafe_f00d;
                send_pkt(p);
                // same word at another byte offset
                p = base_pkt();
                p.MemRead = 1'b1;
                p.MemtoReg = 1'b1;
                p.Rt = 5'd9;
                p.port_o.raw = word_addr(5, 2'd3);
                send_pkt(p);
                p = base_pkt();
                p.MemRead = 1'b1;
                p.MemtoReg = 1'b1;
                p.Rt = 5'd10;
                p.port_o.raw = word_addr(77, 2'd1);
                send_pkt(p);
                wait_writes();
                read_reg(9, val);
                check_word("rd_data r9", val, 32'hcafe_f00d);
                read_reg(10, val);
                check_word("rd_data r10", val, 32'h0000_0000);
                end_test("store then load");

                repeat (N_RANDOM) begin
                        send_pkt(random_pkt());
                end
                wait_writes();
                check_all_regs();
                end_test("random mix");

                check_flag("halt", halt, 1'b0);
                p = base_pkt();
                p.RegWr = 1'b0;
                p.halt = 1'b1;
                send_pkt(p);
                repeat (4) begin
                        @(negedge CLK);
                        check_flag("halt", halt, 1'b1);
                end
                end_test("halt");

                $display("%0d tests run, %0d failed, %0d errors", test_num, test_fails, err_count);
                if (err_count == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* sources.f */
hw/mem_wb_pkg.sv
hw/wait_timer.sv
hw/dmem_ctrl.sv
hw/data_ram.sv
hw/memwb.sv
hw/regfile_wb.sv
hw/mem_wb_top.sv
bench/mem_wb_tb.sv
